//--- hdl/vpu_pkg.sv
// shared widths, opcodes and instruction layout for the vector control pipeline, used by scoped names
package vpu_pkg;

  localparam int REG_WIDTH = 32;
  localparam int CR_ADDR_W = 6;
  localparam int VS_ADDR_W = 5;

  typedef logic [CR_ADDR_W-1:0] cr_addr_t;
  typedef logic [VS_ADDR_W-1:0] vs_addr_t;
  typedef logic [REG_WIDTH-1:0] word_t;

  // operation code is {minor_hi, funct}
  typedef logic [9:0] op_t;

  localparam logic [5:0] COP2_MAJOR = 6'b010010;

  // coprocessor moves sit in the low minor codes, vector ops have bit 25 set
  localparam op_t OP_CFC2   = {4'b0001, 6'b000000};
  localparam op_t OP_MTC2   = {4'b0010, 6'b000000};
  localparam op_t OP_CTC2   = {4'b0011, 6'b000000};
  localparam op_t OP_VMSTC  = {4'b1000, 6'b111000};
  localparam op_t OP_VMCTS  = {4'b1000, 6'b111001};
  localparam op_t OP_VHALF  = {4'b1000, 6'b101000};
  localparam op_t OP_VSATVL = {4'b1000, 6'b101001};

  localparam cr_addr_t CR_VL    = 6'd0;   // vector length
  localparam cr_addr_t CR_VINC0 = 6'd48;  // hardwired zero increment

  // one instruction word, two field layouts
  typedef union packed {
    struct packed {
      logic [5:0] major;     // 31:26
      logic [3:0] minor_hi;  // 25:22
      logic       spare;     // 21
      vs_addr_t   vs;        // 20:16
      cr_addr_t   cr;        // 15:10
      logic [3:0] imm;       // 9:6
      logic [5:0] funct;     // 5:0
    } ctl;
    struct packed {
      logic [5:0] major;
      logic [3:0] minor_hi;
      logic       spare;
      vs_addr_t   rt;        // 20:16
      vs_addr_t   vs;        // 15:11, mtc2 target
      logic [4:0] imm;       // 10:6
      logic [5:0] funct;
    } scl;
  } instr_u;

endpackage

//--- hdl/ctrl_regfile.sv
// control register banks vc, vbase, vinc and vstride behind one read and one write port for vcp_top
`timescale 1ns/100ps

module ctrl_regfile (
  input  logic              clk,
  input  logic              resetn,
  input  vpu_pkg::cr_addr_t rd_addr,
  input  logic              rd_en,
  output vpu_pkg::word_t    rd_data,
  input  logic              wr_en,
  input  vpu_pkg::cr_addr_t wr_addr,
  input  vpu_pkg::word_t    wr_data,
  output vpu_pkg::word_t    vl
);

  vpu_pkg::word_t vc_q     [32];
  vpu_pkg::word_t base_q   [16];
  vpu_pkg::word_t inc_q    [8];
  vpu_pkg::word_t stride_q [8];
  logic [3:0]     wr_bank;
  logic [3:0]     rd_bank;

  // bank select bits in order vc, vbase, vinc and vstride
  function automatic logic [3:0] bank_of(vpu_pkg::cr_addr_t a);
    logic [3:0] b;
    b[0] = a < 6'd32;
    b[1] = a >= 6'd32 && a < vpu_pkg::CR_VINC0;
    b[2] = a >= vpu_pkg::CR_VINC0 && a < 6'd56;
    b[3] = a >= 6'd56;
    return b;
  endfunction

  assign wr_bank = bank_of(wr_addr);
  assign rd_bank = bank_of(rd_addr);

  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      for (int i = 0; i < 32; i++) vc_q[i] <= '0;
      for (int i = 0; i < 16; i++) base_q[i] <= '0;
      for (int i = 0; i < 8; i++) inc_q[i] <= '0;
      for (int i = 0; i < 8; i++) stride_q[i] <= '0;
    end
    else if (wr_en)
    begin
      if (wr_bank[0])
        vc_q[wr_addr[4:0]] <= wr_data;
      if (wr_bank[1])
        base_q[wr_addr[3:0]] <= wr_data;
      if (wr_bank[2] && wr_addr != vpu_pkg::CR_VINC0)  // entry 48 stays zero
        inc_q[wr_addr[2:0]] <= wr_data;
      if (wr_bank[3])
        stride_q[wr_addr[2:0]] <= wr_data;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rd_en)
    begin
      case (1'b1)
        rd_bank[0]: rd_data <= vc_q[rd_addr[4:0]];
        rd_bank[1]: rd_data <= base_q[rd_addr[3:0]];
        rd_bank[2]: rd_data <= inc_q[rd_addr[2:0]];
        default:    rd_data <= stride_q[rd_addr[2:0]];
      endcase
    end
  end

  assign vl = vc_q[vpu_pkg::CR_VL[4:0]];

  a_wr_bank: assert property (@(posedge clk) disable iff (!resetn)
    wr_en |-> $onehot(wr_bank));

endmodule

//--- hdl/scalar_regfile.sv
// vs scalar register file, 32 words with a registered read port and one write port
`timescale 1ns/100ps

module scalar_regfile (
  input  logic              clk,
  input  logic              resetn,
  input  vpu_pkg::vs_addr_t rd_addr,
  input  logic              rd_en,
  output vpu_pkg::word_t    rd_data,
  input  logic              wr_en,
  input  vpu_pkg::vs_addr_t wr_addr,
  input  vpu_pkg::word_t    wr_data
);

  vpu_pkg::word_t vs_q [32];

  always_ff @(posedge clk)
  begin
    if (!resetn)
      for (int i = 0; i < 32; i++) vs_q[i] <= '0;
    else if (wr_en)
      vs_q[wr_addr] <= wr_data;
  end

  // read data holds while the reader is stalled
  always_ff @(posedge clk)
  begin
    if (rd_en)
      rd_data <= vs_q[rd_addr];
  end

endmodule

//--- hdl/vcp_decode.sv
// stage 1 of the control pipeline: instruction register, decode, hazards and stage-2 registers
`timescale 1ns/100ps

module vcp_decode (
  input  logic              clk,
  input  logic              resetn,
  input  vpu_pkg::word_t    instr,
  input  logic              instr_en,
  input  logic              stall2,
  input  vpu_pkg::word_t    fwd_data,
  input  logic              cr_wr_en,
  output logic              instr_wait,
  output vpu_pkg::cr_addr_t cr_rd_addr,
  output logic              cr_rd_en,
  output vpu_pkg::vs_addr_t vs_rd_addr,
  output logic              vs_rd_en,
  output logic              s2_valid,
  output vpu_pkg::op_t      s2_op,
  output vpu_pkg::cr_addr_t s2_cr_dst,
  output vpu_pkg::vs_addr_t s2_vs_dst,
  output vpu_pkg::cr_addr_t rd_cr_addr_s2,
  output logic              fwd_en,
  output vpu_pkg::word_t    fwd_word
);

  vpu_pkg::instr_u   in_word;
  vpu_pkg::instr_u   ir;
  vpu_pkg::op_t      op_s1;
  logic              is_cop2;
  logic              stall1;
  logic              s1_valid;
  logic              reads_cr;
  logic              reads_vs;
  vpu_pkg::cr_addr_t cr_src;
  vpu_pkg::cr_addr_t cr_dst;
  vpu_pkg::vs_addr_t vs_dst;
  logic              s2_vs_we;
  logic              vs_haz;
  logic              fwd_hit;

  assign in_word    = instr;
  assign is_cop2    = in_word.ctl.major == vpu_pkg::COP2_MAJOR;
  assign instr_wait = stall1 & is_cop2;  // foreign words are always taken

  always_ff @(posedge clk)
  begin
    if (!resetn)
      ir <= '0;
    else if (!stall1)
      ir <= (instr_en && is_cop2) ? in_word : '0;  // empty slot decodes as no-op
  end

  assign op_s1 = {ir.ctl.minor_hi, ir.ctl.funct};

  always_comb
  begin
    s1_valid = 1'b1;
    reads_cr = 1'b0;
    reads_vs = 1'b0;
    cr_src   = ir.ctl.cr;
    cr_dst   = ir.ctl.cr;
    vs_dst   = ir.ctl.vs;
    case (op_s1)
      vpu_pkg::OP_CTC2:  ;
      vpu_pkg::OP_CFC2:  reads_cr = 1'b1;
      vpu_pkg::OP_MTC2:  vs_dst = ir.scl.vs;
      vpu_pkg::OP_VMSTC: reads_vs = 1'b1;  // vs in 20:16 to cr in 15:10
      vpu_pkg::OP_VMCTS: reads_cr = 1'b1;  // cr in 15:10 to vs in 20:16
      vpu_pkg::OP_VHALF, vpu_pkg::OP_VSATVL:
      begin
        cr_src = vpu_pkg::CR_VL;
        cr_dst = vpu_pkg::CR_VL;
      end
      default:           s1_valid = 1'b0;
    endcase
  end

  // vs has no bypass, so a read right behind a matching write waits a cycle
  assign s2_vs_we = s2_valid & (s2_op == vpu_pkg::OP_MTC2 || s2_op == vpu_pkg::OP_VMCTS);
  assign vs_haz   = reads_vs & s2_vs_we & (ir.ctl.vs == s2_vs_dst);
  assign stall1   = stall2 | vs_haz;

  // the read happens at the same edge as the stage-2 write, so take the write data
  assign fwd_hit = reads_cr & cr_wr_en & (cr_src == s2_cr_dst);

  assign cr_rd_addr = cr_src;
  assign cr_rd_en   = reads_cr & ~stall1;
  assign vs_rd_addr = ir.ctl.vs;
  assign vs_rd_en   = reads_vs & ~stall1;

  always_ff @(posedge clk)
  begin
    if (!resetn)
    begin
      s2_valid <= 1'b0;
      fwd_en   <= 1'b0;
    end
    else if (!stall2)
    begin
      s2_valid <= s1_valid & ~stall1;  // bubble while stage 1 waits
      fwd_en   <= fwd_hit & ~stall1;
    end
  end

  always_ff @(posedge clk)
  begin
    if (!stall1)
    begin
      s2_op         <= op_s1;
      s2_cr_dst     <= cr_dst;
      s2_vs_dst     <= vs_dst;
      rd_cr_addr_s2 <= cr_src;
      fwd_word      <= fwd_data;
    end
  end

  a_one_dest: assert property (@(posedge clk) disable iff (!resetn)
    !(cr_wr_en && s2_vs_we));

endmodule

//--- hdl/vcp_execute.sv
// stages 2 and 3: operand select, register write data, scalar_in use and the scalar_out handshake
`timescale 1ns/100ps

module vcp_execute #(
  parameter int MVL = 64
) (
  input  logic              clk,
  input  logic              resetn,
  input  vpu_pkg::word_t    scalar_in,
  input  logic              scalar_in_en,
  input  logic              scalar_out_wait,
  input  logic              s2_valid,
  input  vpu_pkg::op_t      s2_op,
  input  vpu_pkg::cr_addr_t s2_cr_dst,
  input  vpu_pkg::vs_addr_t s2_vs_dst,
  input  vpu_pkg::cr_addr_t rd_cr_addr_s2,
  input  vpu_pkg::word_t    cr_rd_data,
  input  vpu_pkg::word_t    vs_rd_data,
  input  vpu_pkg::word_t    vl,
  input  logic              fwd_en,
  input  vpu_pkg::word_t    fwd_word,
  output logic              scalar_in_wait,
  output vpu_pkg::word_t    scalar_out,
  output logic              scalar_out_en,
  output logic              stall2,
  output logic              cr_wr_en,
  output vpu_pkg::cr_addr_t cr_wr_addr,
  output vpu_pkg::word_t    cr_wr_data,
  output logic              vs_wr_en,
  output vpu_pkg::vs_addr_t vs_wr_addr,
  output vpu_pkg::word_t    vs_wr_data,
  output vpu_pkg::word_t    fwd_data
);

  localparam vpu_pkg::word_t MVL_WORD = vpu_pkg::word_t'(MVL);

  logic           is_cfc2;
  logic           needs_in;
  logic           writes_cr;
  logic           writes_vs;
  logic           stall3;
  logic           s3_full;
  vpu_pkg::word_t s3_data;
  vpu_pkg::word_t cr_val;
  vpu_pkg::word_t wr_data;

  assign is_cfc2   = s2_valid & (s2_op == vpu_pkg::OP_CFC2);
  assign needs_in  = s2_valid & (s2_op == vpu_pkg::OP_CTC2 || s2_op == vpu_pkg::OP_MTC2);
  assign writes_cr = s2_valid & (s2_op == vpu_pkg::OP_CTC2 || s2_op == vpu_pkg::OP_VMSTC ||
                                 s2_op == vpu_pkg::OP_VHALF || s2_op == vpu_pkg::OP_VSATVL);
  assign writes_vs = s2_valid & (s2_op == vpu_pkg::OP_MTC2 || s2_op == vpu_pkg::OP_VMCTS);

  assign stall3         = is_cfc2 & s3_full & scalar_out_wait;
  assign stall2         = stall3 | (needs_in & ~scalar_in_en);
  assign scalar_in_wait = ~(needs_in & ~stall2);  // open only on the consuming cycle

  // entry 48 is hardwired, a forwarded write to it never shows
  assign cr_val = (fwd_en && rd_cr_addr_s2 != vpu_pkg::CR_VINC0) ? fwd_word : cr_rd_data;

  always_comb
  begin
    case (s2_op)
      vpu_pkg::OP_CTC2, vpu_pkg::OP_MTC2: wr_data = scalar_in;
      vpu_pkg::OP_VMSTC:  wr_data = vs_rd_data;
      vpu_pkg::OP_VMCTS:  wr_data = cr_val;
      vpu_pkg::OP_VHALF:  wr_data = vl >> 1;  // vl is live, no forward needed
      vpu_pkg::OP_VSATVL: wr_data = (vl > MVL_WORD) ? MVL_WORD : vl;
      default:            wr_data = cr_val;
    endcase
  end

  assign cr_wr_en   = writes_cr & ~stall2;
  assign cr_wr_addr = s2_cr_dst;
  assign cr_wr_data = wr_data;
  assign vs_wr_en   = writes_vs & ~stall2;
  assign vs_wr_addr = s2_vs_dst;
  assign vs_wr_data = wr_data;
  assign fwd_data   = wr_data;

  // stage 3 holds one cfc2 result until the cpu takes it
  always_ff @(posedge clk)
  begin
    if (!resetn)
      s3_full <= 1'b0;
    else if (is_cfc2 && !stall2)
      s3_full <= 1'b1;
    else if (!scalar_out_wait)
      s3_full <= 1'b0;
  end

  always_ff @(posedge clk)
  begin
    if (is_cfc2 && !stall2)
      s3_data <= cr_val;
  end

  assign scalar_out    = s3_data;
  assign scalar_out_en = s3_full;

  a_out_hold: assert property (@(posedge clk) disable iff (!resetn)
    scalar_out_en && scalar_out_wait |=> scalar_out_en && $stable(scalar_out));

endmodule

//--- hdl/vcp_top.sv
// top of the vector control pipeline, joins decode, both register files and execute
`timescale 1ns/100ps

module vcp_top #(
  parameter int MVL = 64
) (
  input  logic           clk,
  input  logic           resetn,
  input  vpu_pkg::word_t instr,
  input  logic           instr_en,
  output logic           instr_wait,
  input  vpu_pkg::word_t scalar_in,
  input  logic           scalar_in_en,
  output logic           scalar_in_wait,
  output vpu_pkg::word_t scalar_out,
  output logic           scalar_out_en,
  input  logic           scalar_out_wait
);

  vpu_pkg::cr_addr_t cr_rd_addr;
  logic              cr_rd_en;
  vpu_pkg::word_t    cr_rd_data;
  vpu_pkg::vs_addr_t vs_rd_addr;
  logic              vs_rd_en;
  vpu_pkg::word_t    vs_rd_data;
  vpu_pkg::word_t    vl;

  logic              s2_valid;
  vpu_pkg::op_t      s2_op;
  vpu_pkg::cr_addr_t s2_cr_dst;
  vpu_pkg::vs_addr_t s2_vs_dst;
  vpu_pkg::cr_addr_t rd_cr_addr_s2;
  logic              fwd_en;
  vpu_pkg::word_t    fwd_word;
  vpu_pkg::word_t    fwd_data;
  logic              stall2;

  logic              cr_wr_en;
  vpu_pkg::cr_addr_t cr_wr_addr;
  vpu_pkg::word_t    cr_wr_data;
  logic              vs_wr_en;
  vpu_pkg::vs_addr_t vs_wr_addr;
  vpu_pkg::word_t    vs_wr_data;

  vcp_decode u_decode (
    .clk           (clk),
    .resetn        (resetn),
    .instr         (instr),
    .instr_en      (instr_en),
    .stall2        (stall2),
    .fwd_data      (fwd_data),
    .cr_wr_en      (cr_wr_en),
    .instr_wait    (instr_wait),
    .cr_rd_addr    (cr_rd_addr),
    .cr_rd_en      (cr_rd_en),
    .vs_rd_addr    (vs_rd_addr),
    .vs_rd_en      (vs_rd_en),
    .s2_valid      (s2_valid),
    .s2_op         (s2_op),
    .s2_cr_dst     (s2_cr_dst),
    .s2_vs_dst     (s2_vs_dst),
    .rd_cr_addr_s2 (rd_cr_addr_s2),
    .fwd_en        (fwd_en),
    .fwd_word      (fwd_word)
  );

  ctrl_regfile u_ctrl_rf (
    .clk     (clk),
    .resetn  (resetn),
    .rd_addr (cr_rd_addr),
    .rd_en   (cr_rd_en),
    .rd_data (cr_rd_data),
    .wr_en   (cr_wr_en),
    .wr_addr (cr_wr_addr),
    .wr_data (cr_wr_data),
    .vl      (vl)
  );

  scalar_regfile u_scalar_rf (
    .clk     (clk),
    .resetn  (resetn),
    .rd_addr (vs_rd_addr),
    .rd_en   (vs_rd_en),
    .rd_data (vs_rd_data),
    .wr_en   (vs_wr_en),
    .wr_addr (vs_wr_addr),
    .wr_data (vs_wr_data)
  );

  vcp_execute #(
    .MVL (MVL)
  ) u_execute (
    .clk             (clk),
    .resetn          (resetn),
    .scalar_in       (scalar_in),
    .scalar_in_en    (scalar_in_en),
    .scalar_out_wait (scalar_out_wait),
    .s2_valid        (s2_valid),
    .s2_op           (s2_op),
    .s2_cr_dst       (s2_cr_dst),
    .s2_vs_dst       (s2_vs_dst),
    .rd_cr_addr_s2   (rd_cr_addr_s2),
    .cr_rd_data      (cr_rd_data),
    .vs_rd_data      (vs_rd_data),
    .vl              (vl),
    .fwd_en          (fwd_en),
    .fwd_word        (fwd_word),
    .scalar_in_wait  (scalar_in_wait),
    .scalar_out      (scalar_out),
    .scalar_out_en   (scalar_out_en),
    .stall2          (stall2),
    .cr_wr_en        (cr_wr_en),
    .cr_wr_addr      (cr_wr_addr),
    .cr_wr_data      (cr_wr_data),
    .vs_wr_en        (vs_wr_en),
    .vs_wr_addr      (vs_wr_addr),
    .vs_wr_data      (vs_wr_data),
    .fwd_data        (fwd_data)
  );

endmodule

//--- testbench/tb_vcp.sv
// testbench for vcp_top, runs a seeded random cop2 program against a register-file model
`timescale 1ns/100ps

module tb_vcp;

  localparam int MVL       = 64;
  localparam int N_RANDOM  = 400;
  localparam int RUN_LIMIT = 20000;  // cycles
  localparam vpu_pkg::word_t MVL_WORD = vpu_pkg::word_t'(MVL);
  localparam vpu_pkg::op_t   OP_NONE  = '1;  // marks a foreign word in the program

  logic           clk;
  logic           resetn;
  vpu_pkg::word_t instr;
  logic           instr_en;
  logic           instr_wait;
  vpu_pkg::word_t scalar_in;
  logic           scalar_in_en;
  logic           scalar_in_wait;
  vpu_pkg::word_t scalar_out;
  logic           scalar_out_en;
  logic           scalar_out_wait;

  vpu_pkg::word_t    prog_word [$];
  vpu_pkg::op_t      prog_op   [$];
  vpu_pkg::cr_addr_t prog_cr   [$];
  vpu_pkg::vs_addr_t prog_vs   [$];
  vpu_pkg::word_t    sin_q     [$];  // scalar_in words in consumption order
  vpu_pkg::word_t    exp_q     [$];  // cfc2 results still owed
  vpu_pkg::word_t    cr_m      [64];
  vpu_pkg::word_t    vs_m      [32];

  int pc;        // next instruction to present
  int sin_drv;   // next scalar_in word to present
  int sin_used;  // words taken by the model
  int mismatch_count;
  int fail_count;
  int cycle;
  bit cfc2_seen;
  bit done;

  vcp_top #(
    .MVL (MVL)
  ) u_dut (
    .clk             (clk),
    .resetn          (resetn),
    .instr           (instr),
    .instr_en        (instr_en),
    .instr_wait      (instr_wait),
    .scalar_in       (scalar_in),
    .scalar_in_en    (scalar_in_en),
    .scalar_in_wait  (scalar_in_wait),
    .scalar_out      (scalar_out),
    .scalar_out_en   (scalar_out_en),
    .scalar_out_wait (scalar_out_wait)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic vpu_pkg::word_t encode(vpu_pkg::op_t op, vpu_pkg::cr_addr_t cr,
                                            vpu_pkg::vs_addr_t vs);
    vpu_pkg::instr_u u;
    u = '0;
    u.ctl.major    = vpu_pkg::COP2_MAJOR;
    u.ctl.minor_hi = op[9:6];
    u.ctl.funct    = op[5:0];
    if (op == vpu_pkg::OP_MTC2)
      u.scl.vs = vs;  // mtc2 names its target in 15:11
    else
    begin
      u.ctl.vs = vs;
      u.ctl.cr = cr;
    end
    return u;
  endfunction

  function automatic bit is_foreign(vpu_pkg::word_t w);
    vpu_pkg::instr_u u;
    u = w;
    return u.ctl.major != vpu_pkg::COP2_MAJOR;
  endfunction

  // a few hot addresses so that neighbours depend on each other
  function automatic vpu_pkg::cr_addr_t pick_cr();
    case ($urandom_range(7, 0))
      0: return vpu_pkg::CR_VL;
      1: return 6'd1;
      2: return 6'd33;
      3: return vpu_pkg::CR_VINC0;
      4: return 6'd50;
      5: return 6'd63;
      default: return vpu_pkg::cr_addr_t'($urandom_range(63, 0));
    endcase
  endfunction

  function automatic vpu_pkg::vs_addr_t pick_vs();
    return vpu_pkg::vs_addr_t'($urandom_range(3, 0));
  endfunction

  function automatic vpu_pkg::word_t pick_data();
    if ($urandom_range(1, 0) == 1)
      return vpu_pkg::word_t'($urandom_range(127, 0));  // near MVL for vsatvl
    return $urandom;
  endfunction

  task automatic add_op(vpu_pkg::op_t op, vpu_pkg::cr_addr_t cr, vpu_pkg::vs_addr_t vs,
                        vpu_pkg::word_t data);
    prog_word.push_back(encode(op, cr, vs));
    prog_op.push_back(op);
    prog_cr.push_back(cr);
    prog_vs.push_back(vs);
    if (op == vpu_pkg::OP_CTC2 || op == vpu_pkg::OP_MTC2)
      sin_q.push_back(data);
  endtask

  task automatic add_foreign();
    vpu_pkg::word_t w;
    w = $urandom;
    w[31:30] = 2'b11;  // never the cop2 major
    prog_word.push_back(w);
    prog_op.push_back(OP_NONE);
    prog_cr.push_back('0);
    prog_vs.push_back('0);
  endtask

  task automatic build_program();
    // one ctc2/cfc2 pair per bank, 48 reads back zero
    add_op(vpu_pkg::OP_CTC2, 6'd5, '0, 32'h1234_5678);
    add_op(vpu_pkg::OP_CFC2, 6'd5, '0, '0);
    add_op(vpu_pkg::OP_CTC2, 6'd40, '0, 32'hdead_beef);
    add_op(vpu_pkg::OP_CFC2, 6'd40, '0, '0);
    add_op(vpu_pkg::OP_CTC2, vpu_pkg::CR_VINC0, '0, 32'hffff_ffff);
    add_op(vpu_pkg::OP_CFC2, vpu_pkg::CR_VINC0, '0, '0);
    add_op(vpu_pkg::OP_CTC2, 6'd60, '0, 32'h0f0f_0f0f);
    add_op(vpu_pkg::OP_CFC2, 6'd60, '0, '0);
    // moves between the vs file and the control space
    add_op(vpu_pkg::OP_MTC2, '0, 5'd3, 32'h0bad_cafe);
    add_op(vpu_pkg::OP_VMSTC, 6'd10, 5'd3, '0);
    add_op(vpu_pkg::OP_CFC2, 6'd10, '0, '0);
    add_op(vpu_pkg::OP_VMCTS, 6'd5, 5'd7, '0);
    add_op(vpu_pkg::OP_VMSTC, 6'd11, 5'd7, '0);
    add_op(vpu_pkg::OP_CFC2, 6'd11, '0, '0);
    // vl above MVL, then below it
    add_op(vpu_pkg::OP_CTC2, vpu_pkg::CR_VL, '0, 32'd200);
    add_op(vpu_pkg::OP_VSATVL, '0, '0, '0);
    add_op(vpu_pkg::OP_CFC2, vpu_pkg::CR_VL, '0, '0);
    add_op(vpu_pkg::OP_VHALF, '0, '0, '0);
    add_op(vpu_pkg::OP_CFC2, vpu_pkg::CR_VL, '0, '0);
    add_op(vpu_pkg::OP_CTC2, vpu_pkg::CR_VL, '0, 32'd37);
    add_op(vpu_pkg::OP_VSATVL, '0, '0, '0);
    add_op(vpu_pkg::OP_CFC2, vpu_pkg::CR_VL, '0, '0);
    add_foreign();
    add_foreign();
    add_op(vpu_pkg::OP_CFC2, 6'd5, '0, '0);
    for (int k = 0; k < N_RANDOM; k++)
    begin
      case ($urandom_range(8, 0))
        0: add_op(vpu_pkg::OP_CTC2, pick_cr(), pick_vs(), pick_data());
        1: add_op(vpu_pkg::OP_MTC2, pick_cr(), pick_vs(), pick_data());
        2: add_op(vpu_pkg::OP_VMSTC, pick_cr(), pick_vs(), '0);
        3: add_op(vpu_pkg::OP_VMCTS, pick_cr(), pick_vs(), '0);
        4: add_op(vpu_pkg::OP_VHALF, pick_cr(), pick_vs(), '0);
        5: add_op(vpu_pkg::OP_VSATVL, pick_cr(), pick_vs(), '0);
        6: add_foreign();
        default: add_op(vpu_pkg::OP_CFC2, pick_cr(), pick_vs(), '0);
      endcase
    end
  endtask

  task automatic check_word(string name, vpu_pkg::word_t got, vpu_pkg::word_t exp);
    if (got !== exp)
    begin
      $display("MISMATCH t=%0t %s got %h expected %h", $time, name, got, exp);
      mismatch_count++;
    end
  endtask

  task automatic check_flag(string name, logic got, logic exp);
    if (got !== exp)
    begin
      $display("MISMATCH t=%0t %s got %b expected %b", $time, name, got, exp);
      mismatch_count++;
    end
  endtask

  task automatic write_cr(vpu_pkg::cr_addr_t a, vpu_pkg::word_t v);
    if (a != vpu_pkg::CR_VINC0)
      cr_m[a] = v;
  endtask

  // architectural effect of one accepted instruction, in program order
  task automatic model_exec(int idx);
    vpu_pkg::cr_addr_t cr;
    vpu_pkg::vs_addr_t vs;
    cr = prog_cr[idx];
    vs = prog_vs[idx];
    case (prog_op[idx])
      vpu_pkg::OP_CTC2:
      begin
        write_cr(cr, sin_q[sin_used]);
        sin_used++;
      end
      vpu_pkg::OP_MTC2:
      begin
        vs_m[vs] = sin_q[sin_used];
        sin_used++;
      end
      vpu_pkg::OP_CFC2:
      begin
        exp_q.push_back(cr_m[cr]);
        cfc2_seen = 1'b1;
      end
      vpu_pkg::OP_VMSTC:  write_cr(cr, vs_m[vs]);
      vpu_pkg::OP_VMCTS:  vs_m[vs] = cr_m[cr];
      vpu_pkg::OP_VHALF:  write_cr(vpu_pkg::CR_VL, cr_m[vpu_pkg::CR_VL] >> 1);
      vpu_pkg::OP_VSATVL:
        write_cr(vpu_pkg::CR_VL, (cr_m[vpu_pkg::CR_VL] > MVL_WORD) ? MVL_WORD : cr_m[vpu_pkg::CR_VL]);
      default: ;  // foreign word
    endcase
  endtask

  // called at each rising edge, sees the values from before the edge
  task automatic step();
    bit took;
    bit sin_xfer;
    took     = instr_en && !instr_wait;
    sin_xfer = scalar_in_en && !scalar_in_wait;
    if (instr_en && is_foreign(instr))
      check_flag("instr_wait", instr_wait, 1'b0);
    if (!cfc2_seen)
      check_flag("scalar_out_en", scalar_out_en, 1'b0);
    if (took)
    begin
      model_exec(pc);
      pc++;
    end
    if (sin_xfer)
      sin_drv++;
    if (scalar_out_en && !scalar_out_wait)
    begin
      if (exp_q.size() == 0)
      begin
        $display("t=%0t scalar_out delivered %h with no CFC2 outstanding", $time, scalar_out);
        fail_count++;
      end
      else
        check_word("scalar_out", scalar_out, exp_q.pop_front());
    end
    if (took || !instr_en)
    begin
      if (pc < prog_word.size() && $urandom_range(3, 0) != 0)
      begin
        instr_en <= 1'b1;
        instr    <= prog_word[pc];
      end
      else
        instr_en <= 1'b0;
    end
    if (sin_xfer || !scalar_in_en)
    begin
      if (sin_drv < sin_q.size() && $urandom_range(2, 0) != 0)
      begin
        scalar_in_en <= 1'b1;
        scalar_in    <= sin_q[sin_drv];
      end
      else
        scalar_in_en <= 1'b0;
    end
    scalar_out_wait <= ($urandom_range(2, 0) == 0);
  endtask

  initial
  begin
    void'($urandom(32'hcd42));
    resetn          = 1'b0;
    instr           = '0;
    instr_en        = 1'b0;
    scalar_in       = '0;
    scalar_in_en    = 1'b0;
    scalar_out_wait = 1'b0;
    pc              = 0;
    sin_drv         = 0;
    sin_used        = 0;
    mismatch_count  = 0;
    fail_count      = 0;
    cfc2_seen       = 1'b0;
    for (int i = 0; i < 64; i++)
      cr_m[i] = '0;
    for (int i = 0; i < 32; i++)
      vs_m[i] = '0;
    build_program();

    repeat (10) @(posedge clk);
    resetn <= 1'b1;
    @(posedge clk);
    check_flag("instr_wait", instr_wait, 1'b0);
    check_flag("scalar_in_wait", scalar_in_wait, 1'b1);
    check_flag("scalar_out_en", scalar_out_en, 1'b0);

    cycle = 0;
    done  = 1'b0;
    while (!done && cycle < RUN_LIMIT)
    begin
      @(posedge clk);
      step();
      cycle++;
      done = (pc == prog_word.size()) && (sin_drv == sin_q.size()) && (exp_q.size() == 0);
    end
    if (!done)
    begin
      $display("timeout: %0d of %0d instructions accepted, %0d results still owed",
               pc, prog_word.size(), exp_q.size());
      fail_count++;
    end

    // idle pipeline must not produce any more results
    cycle = 0;
    while (cycle < 20)
    begin
      @(posedge clk);
      step();
      cycle++;
    end
    if (sin_used != sin_q.size())
    begin
      $display("scalar_in words used by the program %0d, words sent %0d", sin_used, sin_q.size());
      fail_count++;
    end

    $display("errors: %0d mismatches, %0d other failures", mismatch_count, fail_count);
    if (mismatch_count == 0 && fail_count == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

endmodule

//--- files.f
hdl/vpu_pkg.sv
hdl/ctrl_regfile.sv
hdl/scalar_regfile.sv
hdl/vcp_decode.sv
hdl/vcp_execute.sv
hdl/vcp_top.sv
testbench/tb_vcp.sv

//--- run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -j 0 --top-module tb_vcp -f files.f -o vtb &&
  ./obj_dir/vtb | tee sim.log
test -f sim.log && grep -qF '** PASS **' sim.log && ! grep -qF '** FAIL **' sim.log &&
  echo "simulation passed" || { echo "simulation failed"; exit 1; }
